//--- Bender.yml
package:
  name: snake_game

sources:
  # Packages come first, then the game blocks and the top level
  - gameTypesPkg.sv
  - displayPkg.sv
  - gridScanner.sv
  - snakeBodyController.sv
  - appleGenerator.sv
  - collisionDetect.sv
  - scoreTracker.sv
  - digitMux.sv
  - snakeGame.sv
  - target: simulation
    files:
      - tbSnakeGame.sv

//--- appleGenerator.sv
/*
 * Apple generator
 * Runs a Galois LFSR once per frame and moves the apple to the
 * LFSR cell after it is eaten, retrying while that cell is taken
 */
`default_nettype none

module appleGenerator
    import gameTypesPkg::*;
#(
    parameter int maxLength = 32
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     frameEnd,
    input  logic                     goodColl,
    input  logic                     restart,
    input  cellPosT                  scanPos,
    input  cellPosT [maxLength-1:0]  body,
    input  logic [7:0]               snakeLength,
    output logic                     isApple
);

    cellPosT    applePos;
    cellPosT    candidate;
    logic       appleValid;
    logic       searching;
    logic       restartQ;
    logic       candidateFree;
    logic [7:0] lfsr;

    // High nibble gives x and low nibble gives y
    assign candidate = '{x: lfsr[7:4], y: lfsr[3:0]};

    // A candidate must avoid the wall and every live segment
    always_comb begin
        candidateFree = !onBorder(candidate);
        for (int i = 0; i < maxLength; i++) begin
            if ((i < snakeLength) && (body[i] == candidate)) begin
                candidateFree = 1'b0;
            end
        end
    end

    // The eaten apple stays hidden until a free cell turns up
    assign isApple = appleValid && (scanPos == applePos);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lfsr       <= 8'd1;
            applePos   <= APPLE_START;
            appleValid <= 1'b1;
            searching  <= 1'b0;
            restartQ   <= 1'b0;
        end else begin
            restartQ <= restart;
            // Taps 8, 6, 5 and 4 in right-shift form
            if (frameEnd) begin
                lfsr <= {1'b0, lfsr[7:1]} ^ (lfsr[0] ? 8'hB8 : 8'h00);
            end
            if (restart) begin
                applePos   <= APPLE_START;
                appleValid <= 1'b1;
                searching  <= 1'b0;
            end else if ((goodColl && !restartQ) || (searching && frameEnd)) begin
                if (candidateFree) begin
                    applePos   <= candidate;
                    appleValid <= 1'b1;
                    searching  <= 1'b0;
                end else begin
                    appleValid <= 1'b0;
                    searching  <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- collisionDetect.sv
/*
 * Collision detector
 * Flags wall cells and collects head-on-apple and head-on-obstacle
 * hits over a frame, then reports them as one-cycle pulses
 */
`default_nettype none

module collisionDetect
    import gameTypesPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    frameEnd,
    input  cellPosT scanPos,
    input  logic    isHead,
    input  logic    isBody,
    input  logic    isApple,
    output logic    isBorder,
    output logic    goodColl,
    output logic    badColl
);

    logic goodNow;
    logic badNow;
    logic goodSeen;
    logic badSeen;

    assign isBorder = onBorder(scanPos);

    // Hits at the cell being scanned right now
    assign goodNow = isHead && isApple;
    assign badNow  = isHead && (isBody || isBorder);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            goodSeen <= 1'b0;
            badSeen  <= 1'b0;
            goodColl <= 1'b0;
            badColl  <= 1'b0;
        end else if (frameEnd) begin
            // The last cell of the frame is folded in as it is released
            goodColl <= goodSeen || goodNow;
            badColl  <= badSeen || badNow;
            goodSeen <= 1'b0;
            badSeen  <= 1'b0;
        end else begin
            goodColl <= 1'b0;
            badColl  <= 1'b0;
            goodSeen <= goodSeen || goodNow;
            badSeen  <= badSeen || badNow;
        end
    end

endmodule

`default_nettype wire

//--- digitMux.sv
/*
 * Seven-segment digit multiplexer
 * Steps through the ones, tens and hundreds digits and decodes the
 * selected digit for the shared segment lines
 */
`default_nettype none

module digitMux
    import displayPkg::*;
#(
    parameter int digitHoldCycles = 8
) (
    input  logic       clk,
    input  logic       rstN,
    input  bcdScoreT   shownScore,
    output segmentsT   segments,
    output logic [1:0] digitSel
);

    localparam int HoldW = (digitHoldCycles > 1) ? $clog2(digitHoldCycles) : 1;

    logic [HoldW-1:0] holdCnt;
    logic             holdDone;
    logic [1:0]       nextSel;
    logic [3:0]       nextDigit;

    // Hex digit to {g, f, e, d, c, b, a}
    function automatic segmentsT hexToSeg(input logic [3:0] digit);
        case (digit)
            4'h0:    return 7'h3F;
            4'h1:    return 7'h06;
            4'h2:    return 7'h5B;
            4'h3:    return 7'h4F;
            4'h4:    return 7'h66;
            4'h5:    return 7'h6D;
            4'h6:    return 7'h7D;
            4'h7:    return 7'h07;
            4'h8:    return 7'h7F;
            4'h9:    return 7'h6F;
            4'hA:    return 7'h77;
            4'hB:    return 7'h7C;
            4'hC:    return 7'h39;
            4'hD:    return 7'h5E;
            4'hE:    return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    assign holdDone = (holdCnt == HoldW'(digitHoldCycles - 1));

    // Segments are decoded for the select value they will appear with
    always_comb begin
        nextSel = digitSel;
        if (holdDone) begin
            nextSel = (digitSel == DIGIT_HUNDREDS) ? DIGIT_ONES : digitSel + 2'd1;
        end
        case (nextSel)
            DIGIT_TENS:     nextDigit = shownScore.tens;
            DIGIT_HUNDREDS: nextDigit = shownScore.hundreds;
            default:        nextDigit = shownScore.ones;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            holdCnt  <= '0;
            digitSel <= DIGIT_ONES;
            segments <= hexToSeg(4'h0);
        end else begin
            holdCnt  <= holdDone ? '0 : holdCnt + 1'b1;
            digitSel <= nextSel;
            segments <= hexToSeg(nextDigit);
        end
    end

endmodule

`default_nettype wire

//--- displayPkg.sv
/*
 * Display types package
 * BCD score digits, seven-segment lines and digit select codes
 */
`default_nettype none

package displayPkg;

    // Three BCD digits, hundreds in the top nibble
    typedef struct packed {
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
    } bcdScoreT;

    // Segment lines {g, f, e, d, c, b, a}, active high
    typedef logic [6:0] segmentsT;

    // Digit select codes, the ones digit comes first after reset
    localparam logic [1:0] DIGIT_ONES     = 2'd0;
    localparam logic [1:0] DIGIT_TENS     = 2'd1;
    localparam logic [1:0] DIGIT_HUNDREDS = 2'd2;

endpackage

`default_nettype wire

//--- gameTypesPkg.sv
/*
 * Game types package
 * Grid coordinates, cell positions, move directions and cell-kind flags
 * shared by the playfield scanner and the game logic
 */
`default_nettype none

package gameTypesPkg;

    // One cell coordinate on the 16 by 16 playfield
    typedef logic [3:0] coordT;

    typedef struct packed {
        coordT x;
        coordT y;
    } cellPosT;

    // Opposite directions differ only in bit 0
    typedef enum logic [1:0] {
        DIR_UP    = 2'd0,
        DIR_DOWN  = 2'd1,
        DIR_LEFT  = 2'd2,
        DIR_RIGHT = 2'd3
    } dirT;

    // What the cell at the scan position contains
    typedef struct packed {
        logic head;
        logic body;
        logic apple;
        logic border;
    } cellKindT;

    localparam coordT GRID_LAST = 4'd15;

    // The snake starts heading right with its body trailing to the left
    localparam cellPosT START_POS = '{x: 4'd8, y: 4'd8};
    localparam logic [7:0] START_LENGTH = 8'd3;
    localparam cellPosT APPLE_START = '{x: 4'd3, y: 4'd3};

    // The outer ring of cells forms the wall
    function automatic logic onBorder(input cellPosT pos);
        return (pos.x == '0) || (pos.x == GRID_LAST) || (pos.y == '0) || (pos.y == GRID_LAST);
    endfunction

endpackage

`default_nettype wire

//--- gridScanner.sv
/*
 * Playfield scanner
 * Walks the cell coordinates in raster order, one cell per clock,
 * and pulses frameEnd on the last cell of every frame
 */
`default_nettype none

module gridScanner
    import gameTypesPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    output cellPosT scanPos,
    output logic    frameEnd
);

    // The x counter runs fastest and carries into y at the end of each row
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            scanPos <= '0;
        end else begin
            if (scanPos.x == GRID_LAST) begin
                scanPos.x <= '0;
                // Row 15 wraps back to row 0 to start the next frame
                scanPos.y <= (scanPos.y == GRID_LAST) ? '0 : scanPos.y + 4'd1;
            end else begin
                scanPos.x <= scanPos.x + 4'd1;
            end
        end
    end

    // High for exactly one cycle while the bottom-right cell is scanned
    assign frameEnd = (scanPos.x == GRID_LAST) && (scanPos.y == GRID_LAST);

endmodule

`default_nettype wire

//--- scoreTracker.sv
/*
 * Score tracker
 * Counts eaten apples, keeps the high score across games, raises
 * gameOver on a crash and presents the shown score in BCD
 */
`default_nettype none

module scoreTracker
    import displayPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     goodColl,
    input  logic     badColl,
    input  logic     restart,
    output logic     gameOver,
    output bcdScoreT shownScore
);

    logic [7:0] score;
    logic [7:0] scoreNext;
    logic [7:0] highScore;
    logic       restartQ;
    logic       goodValid;
    logic       badValid;

    // Double dabble over the 8 input bits
    function automatic bcdScoreT toBcd(input logic [7:0] value);
        logic [19:0] work;
        work = {12'd0, value};
        for (int i = 0; i < 8; i++) begin
            if (work[11:8] >= 4'd5) begin
                work[11:8] = work[11:8] + 4'd3;
            end
            if (work[15:12] >= 4'd5) begin
                work[15:12] = work[15:12] + 4'd3;
            end
            if (work[19:16] >= 4'd5) begin
                work[19:16] = work[19:16] + 4'd3;
            end
            work = work << 1;
        end
        return bcdScoreT'(work[19:8]);
    endfunction

    // Pulses in the cycle after a restart come from the game just ended
    assign goodValid = goodColl && !restartQ && !gameOver;
    assign badValid  = badColl && !restartQ;

    // Saturates at 255
    assign scoreNext = (goodValid && (score != 8'hFF)) ? score + 8'd1 : score;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            score      <= 8'd0;
            highScore  <= 8'd0;
            gameOver   <= 1'b0;
            restartQ   <= 1'b0;
            shownScore <= '0;
        end else begin
            restartQ <= restart;
            // High score is shown once the game has ended
            shownScore <= toBcd(gameOver ? highScore : score);
            if (restart) begin
                score    <= 8'd0;
                gameOver <= 1'b0;
            end else begin
                score <= scoreNext;
                if (badValid) begin
                    gameOver <= 1'b1;
                    // An apple eaten in the crash frame still counts
                    if (scoreNext > highScore) begin
                        highScore <= scoreNext;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- snakeBodyController.sv
/*
 * Snake body controller
 * Keeps the segment list, length and heading, moves the snake one cell
 * per frame and flags head and body cells at the scan position
 */
`default_nettype none

module snakeBodyController
    import gameTypesPkg::*;
#(
    parameter int maxLength = 32
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     frameEnd,
    input  logic [3:0]               btnDir,
    input  logic                     restart,
    input  logic                     goodColl,
    input  logic                     badColl,
    input  cellPosT                  scanPos,
    output cellPosT [maxLength-1:0]  body,
    output cellPosT                  headPos,
    output logic [7:0]               snakeLength,
    output logic                     isHead,
    output logic                     isBody
);

    dirT     dir;
    dirT     reqDir;
    dirT     nextDir;
    cellPosT newHead;
    logic    growPending;
    logic    freezePending;
    logic    frozen;
    logic    restartQ;

    // Slot i of the start layout sits i cells left of the start head
    function automatic cellPosT startSlot(input int idx);
        cellPosT slot;
        slot.x = coordT'(START_POS.x - idx);
        slot.y = START_POS.y;
        return slot;
    endfunction

    // Lowest-numbered pressed button wins, so scan from the top bit down
    always_comb begin
        reqDir = dir;
        for (int i = 3; i >= 0; i--) begin
            if (btnDir[i]) begin
                reqDir = dirT'(i);
            end
        end
        // A request for the opposite heading flips bit 0 and is ignored
        nextDir = (reqDir == dirT'(dir ^ 2'd1)) ? dir : reqDir;
    end

    // Next head cell one step along the chosen heading
    always_comb begin
        newHead = body[0];
        case (nextDir)
            DIR_UP:    newHead.y = body[0].y - 4'd1;
            DIR_DOWN:  newHead.y = body[0].y + 4'd1;
            DIR_LEFT:  newHead.x = body[0].x - 4'd1;
            default:   newHead.x = body[0].x + 4'd1;
        endcase
    end

    assign headPos = body[0];
    assign isHead  = (body[0] == scanPos);

    // Only the first snakeLength slots are live, slot 0 being the head
    always_comb begin
        isBody = 1'b0;
        for (int i = 1; i < maxLength; i++) begin
            if ((i < snakeLength) && (body[i] == scanPos)) begin
                isBody = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < maxLength; i++) begin
                body[i] <= startSlot(i);
            end
            snakeLength   <= START_LENGTH;
            dir           <= DIR_RIGHT;
            growPending   <= 1'b0;
            freezePending <= 1'b0;
            frozen        <= 1'b0;
            restartQ      <= 1'b0;
        end else begin
            restartQ <= restart;
            if (restart) begin
                // Back to the start layout without taking a step
                for (int i = 0; i < maxLength; i++) begin
                    body[i] <= startSlot(i);
                end
                snakeLength   <= START_LENGTH;
                dir           <= DIR_RIGHT;
                growPending   <= 1'b0;
                freezePending <= 1'b0;
                frozen        <= 1'b0;
            end else if (frameEnd) begin
                growPending   <= 1'b0;
                freezePending <= 1'b0;
                if (frozen || freezePending) begin
                    // A crash stops the snake until the next restart
                    frozen <= 1'b1;
                end else begin
                    dir     <= nextDir;
                    body[0] <= newHead;
                    for (int i = 1; i < maxLength; i++) begin
                        body[i] <= body[i-1];
                    end
                    // Growing keeps the old tail slot live after the shift
                    if (growPending && (snakeLength < maxLength)) begin
                        snakeLength <= snakeLength + 8'd1;
                    end
                end
            end else if (!restartQ) begin
                // Pulses right after a restart belong to the finished game
                if (goodColl) begin
                    growPending <= 1'b1;
                end
                if (badColl) begin
                    freezePending <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- snakeGame.sv
/*
 * Snake game core
 * Scans the playfield, runs the snake, apple and collision rules,
 * tracks the score and drives the multiplexed score display
 */
`default_nettype none

module snakeGame
    import gameTypesPkg::*;
    import displayPkg::*;
#(
    parameter int maxLength       = 32,
    parameter int digitHoldCycles = 8
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       en,
    input  logic [3:0] btnDir,
    input  logic       btnRestart,
    output cellPosT    scanPos,
    output cellKindT   cellKind,
    output segmentsT   segments,
    output logic [1:0] digitSel,
    output logic       gameOver
);

    logic                    coreRstN;
    logic                    frameEnd;
    logic                    restart;
    logic                    isHead;
    logic                    isBody;
    logic                    isApple;
    logic                    isBorder;
    logic                    goodColl;
    logic                    badColl;
    logic [7:0]              snakeLength;
    cellPosT [maxLength-1:0] body;
    bcdScoreT                shownScore;

    // The whole core sits in reset while the chip is disabled
    assign coreRstN = rstN && en;

    // Restart is only honoured at a frame boundary once the game has ended
    assign restart = frameEnd && btnRestart && gameOver;

    gridScanner scanner (
        .clk(clk), .rstN(coreRstN), .scanPos(scanPos), .frameEnd(frameEnd)
    );

    // Head cell is left open here, the flags already cover the display
    snakeBodyController #(.maxLength(maxLength)) snake (
        .clk(clk), .rstN(coreRstN), .frameEnd(frameEnd), .btnDir(btnDir),
        .restart(restart), .goodColl(goodColl), .badColl(badColl),
        .scanPos(scanPos), .body(body), .headPos(), .snakeLength(snakeLength),
        .isHead(isHead), .isBody(isBody)
    );

    appleGenerator #(.maxLength(maxLength)) apple (
        .clk(clk), .rstN(coreRstN), .frameEnd(frameEnd), .goodColl(goodColl),
        .restart(restart), .scanPos(scanPos), .body(body),
        .snakeLength(snakeLength), .isApple(isApple)
    );

    collisionDetect collide (
        .clk(clk), .rstN(coreRstN), .frameEnd(frameEnd), .scanPos(scanPos),
        .isHead(isHead), .isBody(isBody), .isApple(isApple),
        .isBorder(isBorder), .goodColl(goodColl), .badColl(badColl)
    );

    scoreTracker score (
        .clk(clk), .rstN(coreRstN), .goodColl(goodColl), .badColl(badColl),
        .restart(restart), .gameOver(gameOver), .shownScore(shownScore)
    );

    digitMux #(.digitHoldCycles(digitHoldCycles)) display (
        .clk(clk), .rstN(coreRstN), .shownScore(shownScore),
        .segments(segments), .digitSel(digitSel)
    );

    // Each flag comes from the block that owns that kind of cell
    assign cellKind = '{head: isHead, body: isBody, apple: isApple, border: isBorder};

endmodule

`default_nettype wire

//--- sources.f
gameTypesPkg.sv
displayPkg.sv
gridScanner.sv
snakeBodyController.sv
appleGenerator.sv
collisionDetect.sv
scoreTracker.sv
digitMux.sv
snakeGame.sv
tbSnakeGame.sv

//--- tbSnakeGame.sv
/*
 * Snake game testbench
 * Plays many games with random and apple-seeking buttons and checks every
 * scanned cell, gameOver and the score display against a frame-level model
 */
`default_nettype none

module tbSnakeGame
    import gameTypesPkg::*;
    import displayPkg::*;
();

    localparam int maxLen     = 32;
    localparam int holdCycles = 8;
    localparam int gameTarget = 40;
    // Each game is expected to end well inside 300 frames of 256 cells
    localparam int cycleLimit = gameTarget * 300 * 256 + 2048;

    logic       clk;
    logic       rstN;
    logic       en;
    logic [3:0] btnDir;
    logic       btnRestart;
    cellPosT    scanPos;
    cellKindT   cellKind;
    segmentsT   segments;
    logic [1:0] digitSel;
    logic       gameOver;

    // Model of the game state as the DUT holds it during the current frame
    cellPosT    mBody [maxLen];
    int         mLen;
    dirT        mDir;
    logic       mGrowPend;
    logic       mFreezePend;
    logic       mFrozen;
    cellPosT    mApple;
    logic       mAppleValid;
    logic       mSearching;
    logic [7:0] mLfsr;
    int         mScore;
    int         mHigh;
    logic       mGameOver;
    // Collisions gathered this frame and the pulses released from the last one
    logic       mGoodSeen;
    logic       mBadSeen;
    logic       mGoodPulse;
    logic       mBadPulse;
    logic       mRestartQ;

    // Display pipeline, shownPrev is one cycle older than shownNow
    bcdScoreT    shownNow;
    bcdScoreT    shownPrev;
    int          holdCnt;
    logic [1:0]  selNow;
    logic [31:0] rngState;
    int          scanIdx;
    int          gameCount;
    int          applesEaten;
    int          cycleCount = 0;

    snakeGame #(.maxLength(maxLen), .digitHoldCycles(holdCycles)) uut (
        .clk(clk), .rstN(rstN), .en(en), .btnDir(btnDir), .btnRestart(btnRestart),
        .scanPos(scanPos), .cellKind(cellKind), .segments(segments),
        .digitSel(digitSel), .gameOver(gameOver)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles with only %0d games played", cycleCount, gameCount);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkEqual(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            abortRun();
        end
    endtask

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Galois form shifting right, feedback on taps 8, 6, 5 and 4
    function automatic logic [7:0] stepLfsr(input logic [7:0] v);
        return v[0] ? ((v >> 1) ^ 8'b1011_1000) : (v >> 1);
    endfunction

    function automatic logic isWall(input cellPosT p);
        return (p.x == 4'd0) || (p.x == 4'd15) || (p.y == 4'd0) || (p.y == 4'd15);
    endfunction

    function automatic logic cellFree(input cellPosT p);
        logic free;
        free = !isWall(p);
        for (int i = 0; i < mLen; i++) begin
            if (mBody[i] == p) free = 1'b0;
        end
        return free;
    endfunction

    function automatic cellKindT cellView(input cellPosT p);
        cellKindT kind;
        kind.head = (mBody[0] == p);
        kind.body = 1'b0;
        for (int i = 1; i < mLen; i++) begin
            if (mBody[i] == p) kind.body = 1'b1;
        end
        kind.apple  = mAppleValid && (mApple == p);
        kind.border = isWall(p);
        return kind;
    endfunction

    // First pressed button from up towards right wins, a U-turn is refused
    function automatic dirT nextHeading(input logic [3:0] btn, input dirT cur);
        dirT  req;
        dirT  back;
        logic found;
        req   = cur;
        found = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (btn[i] && !found) begin
                req   = dirT'(i);
                found = 1'b1;
            end
        end
        case (cur)
            DIR_UP:   back = DIR_DOWN;
            DIR_DOWN: back = DIR_UP;
            DIR_LEFT: back = DIR_RIGHT;
            default:  back = DIR_LEFT;
        endcase
        return (req == back) ? cur : req;
    endfunction

    function automatic cellPosT moveHead(input cellPosT from, input dirT d);
        cellPosT to;
        to = from;
        case (d)
            DIR_UP:   to.y = from.y - 4'd1;
            DIR_DOWN: to.y = from.y + 4'd1;
            DIR_LEFT: to.x = from.x - 4'd1;
            default:  to.x = from.x + 4'd1;
        endcase
        return to;
    endfunction

    function automatic bcdScoreT toDigits(input int value);
        bcdScoreT d;
        d.hundreds = 4'(value / 100);
        d.tens     = 4'((value / 10) % 10);
        d.ones     = 4'(value % 10);
        return d;
    endfunction

    // Segment order is {g, f, e, d, c, b, a}
    function automatic segmentsT digitSegments(input logic [3:0] d);
        case (d)
            4'd0:    return 7'b0111111;
            4'd1:    return 7'b0000110;
            4'd2:    return 7'b1011011;
            4'd3:    return 7'b1001111;
            4'd4:    return 7'b1100110;
            4'd5:    return 7'b1101101;
            4'd6:    return 7'b1111101;
            4'd7:    return 7'b0000111;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1101111;
            default: return 7'b0000000;
        endcase
    endfunction

    // Start layout, keeps the high score and the LFSR running
    task automatic resetGame();
        for (int i = 0; i < maxLen; i++) begin
            mBody[i].x = START_POS.x - 4'(i);
            mBody[i].y = START_POS.y;
        end
        mLen        = START_LENGTH;
        mDir        = DIR_RIGHT;
        mGrowPend   = 1'b0;
        mFreezePend = 1'b0;
        mFrozen     = 1'b0;
        mApple      = APPLE_START;
        mAppleValid = 1'b1;
        mSearching  = 1'b0;
        mScore      = 0;
        mGameOver   = 1'b0;
    endtask

    task automatic checkCycle();
        cellPosT    pos;
        cellKindT   kind;
        logic [3:0] digit;
        pos  = '{x: scanIdx[3:0], y: scanIdx[7:4]};
        kind = cellView(pos);
        checkEqual("scanPos", scanPos, pos);
        checkEqual("cellKind", cellKind, kind);
        checkEqual("gameOver", gameOver, mGameOver);
        checkEqual("digitSel", digitSel, selNow);
        case (selNow)
            DIGIT_TENS:     digit = shownPrev.tens;
            DIGIT_HUNDREDS: digit = shownPrev.hundreds;
            default:        digit = shownPrev.ones;
        endcase
        checkEqual("segments", segments, digitSegments(digit));
        if (kind.head && kind.apple) mGoodSeen = 1'b1;
        if (kind.head && (kind.body || kind.border)) mBadSeen = 1'b1;
        // Score register lags the game state by a cycle, segments by two
        shownPrev = shownNow;
        shownNow  = toDigits(mGameOver ? mHigh : mScore);
        if (holdCnt == holdCycles - 1) begin
            holdCnt = 0;
            selNow  = (selNow == DIGIT_HUNDREDS) ? DIGIT_ONES : selNow + 2'd1;
        end else begin
            holdCnt++;
        end
    endtask

    // Edge at the last cell of a frame, apple search uses the old body and LFSR
    task automatic frameEndUpdate();
        logic    restart;
        cellPosT cand;
        restart    = btnRestart && mGameOver;
        mGoodPulse = mGoodSeen;
        mBadPulse  = mBadSeen;
        mGoodSeen  = 1'b0;
        mBadSeen   = 1'b0;
        mRestartQ  = restart;
        cand = '{x: mLfsr[7:4], y: mLfsr[3:0]};
        if (!restart && mSearching && cellFree(cand)) begin
            mApple      = cand;
            mAppleValid = 1'b1;
            mSearching  = 1'b0;
        end
        mLfsr = stepLfsr(mLfsr);
        if (restart) begin
            resetGame();
            gameCount++;
        end else if (mFrozen || mFreezePend) begin
            mFrozen = 1'b1;
        end else begin
            mDir = nextHeading(btnDir, mDir);
            for (int i = maxLen - 1; i > 0; i--) mBody[i] = mBody[i-1];
            mBody[0] = moveHead(mBody[0], mDir);
            if (mGrowPend && (mLen < maxLen)) mLen++;
        end
        mGrowPend   = 1'b0;
        mFreezePend = 1'b0;
    endtask

    // Edge after the first cell, where last frame's collisions take effect
    task automatic pulseUpdate();
        int      nextScore;
        cellPosT cand;
        if (!mRestartQ) begin
            if (mBadPulse) mFreezePend = 1'b1;
            if (mGoodPulse) begin
                mGrowPend = 1'b1;
                cand = '{x: mLfsr[7:4], y: mLfsr[3:0]};
                mAppleValid = cellFree(cand);
                mSearching  = !cellFree(cand);
                if (cellFree(cand)) mApple = cand;
            end
            nextScore = mScore;
            if (mGoodPulse && !mGameOver && (mScore < 255)) begin
                nextScore = mScore + 1;
                applesEaten++;
            end
            mScore = nextScore;
            if (mBadPulse) begin
                mGameOver = 1'b1;
                if (nextScore > mHigh) mHigh = nextScore;
            end
        end
    endtask

    // Mostly steer toward the apple, sometimes press random button sets
    task automatic driveButtons();
        dirT toward;
        rngState = nextRandom(rngState);
        if (mApple.x > mBody[0].x) toward = DIR_RIGHT;
        else if (mApple.x < mBody[0].x) toward = DIR_LEFT;
        else if (mApple.y > mBody[0].y) toward = DIR_DOWN;
        else toward = DIR_UP;
        case (rngState[1:0])
            2'd0:    btnDir = rngState[7:4];
            2'd3:    btnDir = 4'b0000;
            default: btnDir = 4'b0001 << toward;
        endcase
        btnRestart = rngState[8];
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        en          = 1'b1;
        btnDir      = 4'b0000;
        btnRestart  = 1'b0;
        rngState    = 32'd25;
        mLfsr       = 8'd1;
        mHigh       = 0;
        mGoodSeen   = 1'b0;
        mBadSeen    = 1'b0;
        mGoodPulse  = 1'b0;
        mBadPulse   = 1'b0;
        mRestartQ   = 1'b0;
        resetGame();
        shownNow    = '0;
        shownPrev   = '0;
        holdCnt     = 0;
        selNow      = DIGIT_ONES;
        scanIdx     = 0;
        gameCount   = 0;
        applesEaten = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        // One pass per clock, checked and driven on the falling edge
        while (gameCount < gameTarget) begin
            checkCycle();
            if (scanIdx == 0) begin
                pulseUpdate();
                driveButtons();
            end
            if (scanIdx == 255) frameEndUpdate();
            @(posedge clk);
            @(negedge clk);
            scanIdx = (scanIdx + 1) % 256;
        end
        if (applesEaten > 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("No apple was eaten in %0d games", gameCount);
            abortRun();
        end
    end

endmodule

`default_nettype wire
